// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the accelerator testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sim.f \
  --top-module tb_redmule

./obj_dir/Vtb_redmule | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run.sh: simulation reported failure"
  exit 1
fi

echo "run.sh: simulation finished without failure"
exit 0

// ==== sim.f ====
src/redmule_pkg.sv
src/redmule_loader.sv
src/redmule_operand_buffer.sv
src/redmule_engine.sv
src/redmule_top.sv
tests/redmule_properties.sv
tests/tb_redmule.sv

// ==== src/redmule_engine.sv ====
// ----------------------------------------
// Compute engine: walks Z positions and
// runs a two-stage multiply/add pipeline
// ----------------------------------------

module redmule_engine import redmule_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     run_i,
  input  word_t [ARRAY_HEIGHT-1:0] x_row_i,
  input  word_t [ARRAY_HEIGHT-1:0] w_col_i,
  input  word_t                    y_elem_i,
  output row_t                     rd_row_o,
  output col_t                     rd_col_o,
  output logic                     z_valid_o,
  output word_t                    z_data_o,
  output logic                     done_o
);

  logic  running_q;
  row_t  row_q;
  col_t  col_q;
  logic  last_pos;

  logic  s1_valid_q;
  logic  s1_last_q;
  word_t prod_q [ARRAY_HEIGHT];
  word_t bias_q;
  word_t sum;

  assign rd_row_o = row_q;
  assign rd_col_o = col_q;
  assign last_pos = (row_q == row_t'(ARRAY_WIDTH - 1)) && (col_q == col_t'(TILE_N - 1));

  // Position sequencer, one Z element per cycle in row-major order
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      running_q <= 1'b0;
      row_q     <= '0;
      col_q     <= '0;
    end else if (run_i) begin
      running_q <= 1'b1;
      row_q     <= '0;
      col_q     <= '0;
    end else if (running_q) begin
      if (col_q == col_t'(TILE_N - 1)) begin
        col_q <= '0;
        row_q <= row_q + 1'b1;
        if (last_pos) running_q <= 1'b0;
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // Stage 1 tags, the pipeline drains after the sequencer stops
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s1_last_q  <= 1'b0;
      z_valid_o  <= 1'b0;
      done_o     <= 1'b0;
    end else begin
      s1_valid_q <= running_q;
      s1_last_q  <= running_q && last_pos;
      z_valid_o  <= s1_valid_q;
      done_o     <= s1_valid_q && s1_last_q;
    end
  end

  // Products truncated to the element width
  always_ff @(posedge clk_i) begin
    for (int k = 0; k < ARRAY_HEIGHT; k++) begin
      prod_q[k] <= word_t'(x_row_i[k] * w_col_i[k]);
    end
    bias_q <= y_elem_i;
  end

  // Adder tree with bias, wraps modulo 2^DATA_W
  always_comb begin
    sum = bias_q;
    for (int k = 0; k < ARRAY_HEIGHT; k++) begin
      sum = sum + prod_q[k];
    end
  end

  always_ff @(posedge clk_i) begin
    z_data_o <= sum;
  end

endmodule : redmule_engine

// ==== src/redmule_loader.sv ====
// ----------------------------------------
// Input loader: takes X, W and Y words in
// order after start and fills the buffer
// ----------------------------------------

module redmule_loader import redmule_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     start_i,
  input  logic     in_valid_i,
  input  word_t    in_data_i,
  input  logic     done_i,
  output logic     wr_en_o,
  output operand_e wr_sel_o,
  output idx_t     wr_addr_o,
  output word_t    wr_data_o,
  output logic     run_o,
  output logic     busy_o
);

  ld_state_e state_q;
  idx_t      cnt_q;
  logic      loading;
  logic      last_word;

  assign loading   = (state_q == LD_X) || (state_q == LD_W) || (state_q == LD_Y);
  assign last_word = (cnt_q == idx_t'(TILE_WORDS - 1));

  // Write port follows the input strobe directly
  assign wr_en_o   = in_valid_i && loading;
  assign wr_addr_o = cnt_q;
  assign wr_data_o = in_data_i;
  assign busy_o    = (state_q != LD_IDLE);

  always_comb begin
    case (state_q)
      LD_W:    wr_sel_o = OPND_W;
      LD_Y:    wr_sel_o = OPND_Y;
      default: wr_sel_o = OPND_X;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= LD_IDLE;
      cnt_q   <= '0;
      run_o   <= 1'b0;
    end else begin
      run_o <= 1'b0;
      case (state_q)
        LD_IDLE: begin
          cnt_q <= '0;
          if (start_i) state_q <= LD_X;
        end
        LD_X, LD_W, LD_Y: begin
          if (in_valid_i) begin
            cnt_q <= cnt_q + 1'b1;
            if (last_word) begin
              case (state_q)
                LD_X:    state_q <= LD_W;
                LD_W:    state_q <= LD_Y;
                default: begin
                  state_q <= LD_WAIT;
                  run_o   <= 1'b1;
                end
              endcase
            end
          end
        end
        LD_WAIT: if (done_i) state_q <= LD_IDLE;
        default: state_q <= LD_IDLE;
      endcase
    end
  end

endmodule : redmule_loader

// ==== src/redmule_operand_buffer.sv ====
// ----------------------------------------
// Operand storage for X, W and Y with one
// write port and combinational reads
// ----------------------------------------

module redmule_operand_buffer import redmule_pkg::*; (
  input  logic                     clk_i,
  input  logic                     wr_en_i,
  input  operand_e                 wr_sel_i,
  input  idx_t                     wr_addr_i,
  input  word_t                    wr_data_i,
  input  row_t                     rd_row_i,
  input  col_t                     rd_col_i,
  output word_t [ARRAY_HEIGHT-1:0] x_row_o,
  output word_t [ARRAY_HEIGHT-1:0] w_col_o,
  output word_t                    y_elem_o
);

  // Row-major storage of the three operands
  word_t x_mem [TILE_WORDS];
  word_t w_mem [TILE_WORDS];
  word_t y_mem [TILE_WORDS];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      case (wr_sel_i)
        OPND_X:  x_mem[wr_addr_i] <= wr_data_i;
        OPND_W:  w_mem[wr_addr_i] <= wr_data_i;
        default: y_mem[wr_addr_i] <= wr_data_i;
      endcase
    end
  end

  // X[r][k] sits at r*K+k, W[k][c] at k*N+c
  always_comb begin
    idx_t x_addr;
    idx_t w_addr;
    for (int k = 0; k < ARRAY_HEIGHT; k++) begin
      x_addr     = idx_t'(rd_row_i * ARRAY_HEIGHT + k);
      w_addr     = idx_t'(k * TILE_N + rd_col_i);
      x_row_o[k] = x_mem[x_addr];
      w_col_o[k] = w_mem[w_addr];
    end
  end

  assign y_elem_o = y_mem[idx_t'(rd_row_i * TILE_N + rd_col_i)];

endmodule : redmule_operand_buffer

// ==== src/redmule_pkg.sv ====
// ----------------------------------------
// Shared sizes, index types and enums for
// the tile matrix-multiply accelerator
// ----------------------------------------

package redmule_pkg;

  // Element width and tile geometry, Z[M][N] = X[M][K] * W[K][N] + Y[M][N]
  localparam int unsigned DATA_W       = 16;
  localparam int unsigned ARRAY_HEIGHT = 4;
  localparam int unsigned ARRAY_WIDTH  = 4;
  localparam int unsigned TILE_N       = 4;

  localparam int unsigned X_WORDS    = ARRAY_WIDTH * ARRAY_HEIGHT;
  localparam int unsigned W_WORDS    = ARRAY_HEIGHT * TILE_N;
  localparam int unsigned Y_WORDS    = ARRAY_WIDTH * TILE_N;
  localparam int unsigned XW_MAX     = (X_WORDS > W_WORDS) ? X_WORDS : W_WORDS;
  localparam int unsigned TILE_WORDS = (XW_MAX > Y_WORDS) ? XW_MAX : Y_WORDS;
  localparam int unsigned IDX_W      = $clog2(TILE_WORDS);

  typedef logic [DATA_W-1:0]              word_t;
  typedef logic [IDX_W-1:0]               idx_t;
  typedef logic [$clog2(ARRAY_WIDTH)-1:0] row_t;
  typedef logic [$clog2(TILE_N)-1:0]      col_t;

  // Destination buffer of an incoming word
  typedef enum logic [1:0] {OPND_X, OPND_W, OPND_Y} operand_e;

  typedef enum logic [2:0] {LD_IDLE, LD_X, LD_W, LD_Y, LD_WAIT} ld_state_e;

endpackage : redmule_pkg

// ==== src/redmule_top.sv ====
// ----------------------------------------
// Accelerator top: loader feeds the buffer,
// engine reads it and streams Z out
// ----------------------------------------

module redmule_top import redmule_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  start_i,
  input  logic  in_valid_i,
  input  word_t in_data_i,
  output logic  z_valid_o,
  output word_t z_data_o,
  output logic  busy_o,
  output logic  done_o
);

  // Loader to buffer write port
  logic     wr_en;
  operand_e wr_sel;
  idx_t     wr_addr;
  word_t    wr_data;

  logic     run;

  // Engine read request and buffer read data
  row_t                     rd_row;
  col_t                     rd_col;
  word_t [ARRAY_HEIGHT-1:0] x_row;
  word_t [ARRAY_HEIGHT-1:0] w_col;
  word_t                    y_elem;

  redmule_loader i_redmule_loader (
    .clk_i      ( clk_i      ),
    .rst_i      ( rst_i      ),
    .start_i    ( start_i    ),
    .in_valid_i ( in_valid_i ),
    .in_data_i  ( in_data_i  ),
    .done_i     ( done_o     ),
    .wr_en_o    ( wr_en      ),
    .wr_sel_o   ( wr_sel     ),
    .wr_addr_o  ( wr_addr    ),
    .wr_data_o  ( wr_data    ),
    .run_o      ( run        ),
    .busy_o     ( busy_o     )
  );

  redmule_operand_buffer i_redmule_operand_buffer (
    .clk_i     ( clk_i   ),
    .wr_en_i   ( wr_en   ),
    .wr_sel_i  ( wr_sel  ),
    .wr_addr_i ( wr_addr ),
    .wr_data_i ( wr_data ),
    .rd_row_i  ( rd_row  ),
    .rd_col_i  ( rd_col  ),
    .x_row_o   ( x_row   ),
    .w_col_o   ( w_col   ),
    .y_elem_o  ( y_elem  )
  );

  redmule_engine i_redmule_engine (
    .clk_i     ( clk_i     ),
    .rst_i     ( rst_i     ),
    .run_i     ( run       ),
    .x_row_i   ( x_row     ),
    .w_col_i   ( w_col     ),
    .y_elem_i  ( y_elem    ),
    .rd_row_o  ( rd_row    ),
    .rd_col_o  ( rd_col    ),
    .z_valid_o ( z_valid_o ),
    .z_data_o  ( z_data_o  ),
    .done_o    ( done_o    )
  );

endmodule : redmule_top

// ==== tests/redmule_properties.sv ====
// ----------------------------------------
// Protocol properties on the accelerator
// top-level outputs, attached by bind
// ----------------------------------------

module redmule_properties (
  input logic clk_i,
  input logic rst_i,
  input logic z_valid_i,
  input logic busy_i,
  input logic done_i
);

  valid_in_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    z_valid_i |-> busy_i)
    else $error("Z word valid while the accelerator is not busy");

  done_with_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    done_i |-> z_valid_i)
    else $error("done pulse without a valid Z word");

  idle_after_done: assert property (@(posedge clk_i) disable iff (rst_i)
    done_i |=> !busy_i)
    else $error("busy still high in the cycle after done");

  // Outputs are quiet right after any reset cycle
  quiet_after_reset: assert property (@(posedge clk_i)
    rst_i |=> (!z_valid_i && !done_i))
    else $error("output valid in the cycle after reset");

endmodule : redmule_properties

bind redmule_top redmule_properties i_redmule_properties (
  .clk_i     ( clk_i     ),
  .rst_i     ( rst_i     ),
  .z_valid_i ( z_valid_o ),
  .busy_i    ( busy_o    ),
  .done_i    ( done_o    )
);

// ==== tests/tb_redmule.sv ====
// ----------------------------------------
// Testbench for the tile accelerator: LFSR
// tiles go in, Z is checked against a model
// ----------------------------------------

module tb_redmule import redmule_pkg::*; ();

  localparam int unsigned NUM_TESTS  = 6;
  localparam int unsigned JOB_CYCLES = 3 * TILE_WORDS * 4 + 40;
  localparam int unsigned WAIT_LIMIT = 200;

  logic  clk = 1'b0;
  logic  rst;
  logic  start;
  logic  in_valid;
  word_t in_data;
  logic  z_valid;
  word_t z_data;
  logic  busy;
  logic  done;

  logic [31:0] lfsr_q;
  word_t       x_m   [TILE_WORDS];
  word_t       w_m   [TILE_WORDS];
  word_t       y_m   [TILE_WORDS];
  word_t       exp_z [TILE_WORDS];
  word_t       z_q   [$];
  int          done_cnt;
  int          done_pos;
  int          errors;
  int          test_err;
  int          pass_cnt;
  int          fail_cnt;

  redmule_top dut (
    .clk_i      ( clk      ),
    .rst_i      ( rst      ),
    .start_i    ( start    ),
    .in_valid_i ( in_valid ),
    .in_data_i  ( in_data  ),
    .z_valid_o  ( z_valid  ),
    .z_data_o   ( z_data   ),
    .busy_o     ( busy     ),
    .done_o     ( done     )
  );

  always #4 clk = ~clk;

  // Budget per test covers 48 words with worst-case gaps plus pipeline drain
  initial begin
    #(NUM_TESTS * JOB_CYCLES * 8);
    $display("ERROR: watchdog expired, the tests did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

  // Capture the Z stream mid-cycle where registered outputs are stable
  always @(negedge clk) begin
    if (z_valid) begin
      z_q.push_back(z_data);
      if (done) begin
        done_cnt++;
        done_pos = z_q.size();
      end
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic fill_random(input bit identity_w);
    for (int i = 0; i < TILE_WORDS; i++) begin
      x_m[i] = word_t'(draw_bits(DATA_W));
      y_m[i] = word_t'(draw_bits(DATA_W));
      if (identity_w)
        w_m[i] = (i / TILE_N == i % TILE_N) ? word_t'(1) : word_t'(0);
      else
        w_m[i] = word_t'(draw_bits(DATA_W));
    end
  endtask

  // Z[r][c] is Y[r][c] plus the sum over k of X[r][k]*W[k][c] modulo 2^16
  task automatic compute_model();
    word_t acc;
    for (int r = 0; r < ARRAY_WIDTH; r++) begin
      for (int c = 0; c < TILE_N; c++) begin
        acc = y_m[r * TILE_N + c];
        for (int k = 0; k < ARRAY_HEIGHT; k++) begin
          acc = acc + word_t'(x_m[r * ARRAY_HEIGHT + k] * w_m[k * TILE_N + c]);
        end
        exp_z[r * TILE_N + c] = acc;
      end
    end
  endtask

  // With W = I the result reduces to X + Y element by element
  task automatic expect_identity();
    for (int r = 0; r < ARRAY_WIDTH; r++) begin
      for (int c = 0; c < TILE_N; c++) begin
        exp_z[r * TILE_N + c] = x_m[r * ARRAY_HEIGHT + c] + y_m[r * TILE_N + c];
      end
    end
  endtask

  task automatic check_no_output();
    assert (!z_valid) else begin
      $display("MISMATCH at %0t: z_valid high before all operands were loaded", $time);
      errors++;
    end
  endtask

  task automatic send_word(input word_t data, input bit gaps);
    int idle;
    idle = gaps ? int'(draw_bits(2)) : 0;
    for (int i = 0; i < idle; i++) begin
      in_valid = 1'b0;
      check_no_output();
      @(negedge clk);
    end
    in_valid = 1'b1;
    in_data  = data;
    check_no_output();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic load_job(input bit gaps);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    for (int i = 0; i < TILE_WORDS; i++) send_word(x_m[i], gaps);
    for (int i = 0; i < TILE_WORDS; i++) send_word(w_m[i], gaps);
    for (int i = 0; i < TILE_WORDS; i++) send_word(y_m[i], gaps);
  endtask

  // Optional noise on start and in_valid while the job computes
  task automatic wait_done(input bit noise);
    int cycles;
    cycles = 0;
    while (!done && cycles < WAIT_LIMIT) begin
      if (noise) begin
        start    = 1'(draw_bits(1));
        in_valid = 1'(draw_bits(1));
        in_data  = word_t'(draw_bits(DATA_W));
      end
      @(negedge clk);
      cycles++;
    end
    start    = 1'b0;
    in_valid = 1'b0;
    if (cycles >= WAIT_LIMIT) begin
      $display("ERROR: no done pulse within %0d cycles at time %0t", WAIT_LIMIT, $time);
      errors++;
    end else begin
      @(negedge clk);
      assert (!busy) else begin
        $display("MISMATCH at %0t: busy still high one cycle after done", $time);
        errors++;
      end
    end
  endtask

  task automatic check_result();
    assert (z_q.size() == Y_WORDS) else begin
      $display("MISMATCH at %0t: got %0d Z words, expected %0d", $time, z_q.size(), Y_WORDS);
      errors++;
    end
    for (int i = 0; i < z_q.size() && i < Y_WORDS; i++) begin
      assert (z_q[i] == exp_z[i]) else begin
        $display("MISMATCH at %0t: Z[%0d] got %h expected %h", $time, i, z_q[i], exp_z[i]);
        errors++;
      end
    end
    assert (done_cnt == 1 && done_pos == Y_WORDS) else begin
      $display("MISMATCH at %0t: done seen %0d times, at word %0d", $time, done_cnt, done_pos);
      errors++;
    end
  endtask

  task automatic run_job(input bit gaps, input bit noise);
    z_q.delete();
    done_cnt = 0;
    done_pos = 0;
    load_job(gaps);
    wait_done(noise);
    check_result();
  endtask

  task automatic finish_test(input string name);
    if (errors == test_err) begin
      pass_cnt++;
      $display("PASS  %s", name);
    end else begin
      fail_cnt++;
      $display("FAIL  %s", name);
    end
    test_err = errors;
  endtask

  initial begin
    lfsr_q   = 32'hfe61_4f0d;
    rst      = 1'b1;
    start    = 1'b0;
    in_valid = 1'b0;
    in_data  = '0;
    errors   = 0;
    test_err = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    done_cnt = 0;
    done_pos = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Idle outputs must ignore stray input strobes
    repeat (20) begin
      in_valid = 1'(draw_bits(1));
      in_data  = word_t'(draw_bits(DATA_W));
      assert (!busy && !z_valid && !done) else begin
        $display("MISMATCH at %0t: busy, z_valid or done active without a job", $time);
        errors++;
      end
      @(negedge clk);
    end
    in_valid = 1'b0;
    finish_test("reset state");

    fill_random(1'b0);
    compute_model();
    run_job(1'b0, 1'b0);
    finish_test("random tile");

    fill_random(1'b1);
    expect_identity();
    run_job(1'b0, 1'b0);
    finish_test("identity weights");

    fill_random(1'b0);
    compute_model();
    run_job(1'b1, 1'b0);
    finish_test("gapped input");

    fill_random(1'b0);
    compute_model();
    run_job(1'b0, 1'b1);
    fill_random(1'b0);
    compute_model();
    run_job(1'b1, 1'b0);
    finish_test("ignored strobes");

    // Second start follows directly in the cycle busy drops
    fill_random(1'b0);
    compute_model();
    run_job(1'b0, 1'b0);
    fill_random(1'b0);
    compute_model();
    run_job(1'b0, 1'b0);
    finish_test("back-to-back jobs");

    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : tb_redmule
